/* files.f */
verilog/rv_pkg.sv
verilog/dec_if.sv
verilog/idu.sv
verilog/gpr_file.sv
verilog/exu_alu.sv
verilog/wbu.sv
verilog/rv_core.sv
sim/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_rv_core.sv */
module tb_rv_core;

    // Roughly 150 cycles of tests, so this leaves a wide margin
    localparam int MAX_CYCLES  = 2000;
    localparam int RETIRE_WAIT = 8;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    // ADDI SLTI SLTIU XORI ORI ANDI SLLI SRLI SRAI
    localparam logic [2:0] IMM_F3 [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    // ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    localparam logic [2:0] REG_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5,
                                           3'd6, 3'd7};
    localparam logic REG_ALT [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    localparam logic [2:0] BR_F3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    logic        i_clk = 1'b0;
    logic        i_arst_n;
    logic        i_inst_valid;
    logic [31:0] i_inst;
    logic [31:0] o_pc;
    logic        o_retire;
    logic        o_rd_wr_en;
    logic [4:0]  o_rd_id;
    logic [31:0] o_rd_data;
    logic        o_end_flag;

    logic [31:0] model_x [32];
    logic [31:0] model_pc;
    int          errors = 0;
    int          cycles = 0;
    int          seed   = 32'h2871_79fd;

    rv_core #(
        .RESET_PC (32'h0)
    ) uut (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .o_pc         (o_pc),
        .o_retire     (o_retire),
        .o_rd_wr_en   (o_rd_wr_en),
        .o_rd_id      (o_rd_id),
        .o_rd_data    (o_rd_data),
        .o_end_flag   (o_end_flag)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ISA results for the arithmetic group and the branch conditions
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> b[4:0]);
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic send_inst(input logic [31:0] inst);
        int waited;
        waited = 0;
        @(posedge i_clk);
        i_inst       <= inst;
        i_inst_valid <= 1'b1;
        @(posedge i_clk);
        i_inst_valid <= 1'b0;
        @(negedge i_clk);
        while (!o_retire && waited < RETIRE_WAIT) begin
            @(negedge i_clk);
            waited++;
        end
        if (!o_retire) begin
            $display("Error: instruction %h at pc %h never retired", inst, model_pc);
            errors++;
        end
    endtask

    task automatic exec_check(input logic [31:0] inst, input logic exp_wr,
                              input logic [31:0] exp_data, input logic [31:0] exp_pc,
                              input logic exp_end);
        logic [4:0] rd;
        rd = inst[11:7];
        send_inst(inst);
        check_val("o_rd_wr_en", 32'(exp_wr), 32'(o_rd_wr_en));
        if (exp_wr) begin
            check_val("o_rd_id", 32'(rd), 32'(o_rd_id));
            check_val("o_rd_data", exp_data, o_rd_data);
            if (rd != 5'd0) begin
                model_x[rd] = exp_data;
            end
        end
        check_val("o_end_flag", 32'(exp_end), 32'(o_end_flag));
        check_val("o_pc", exp_pc, o_pc);
        model_pc = exp_pc;
    endtask

    // LUI then ADDI, with the upper part rounded for the sign of the low 12 bits
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        exec_check(enc_u(hi[31:12], rd, OPC_LUI), 1'b1, {hi[31:12], 12'h000},
                   model_pc + 32'd4, 1'b0);
        exec_check(enc_i(v[11:0], rd, 3'b000, rd, OPC_OP_IMM), 1'b1, v, model_pc + 32'd4, 1'b0);
    endtask

    task automatic test_reset();
        check_val("o_pc", 32'h0, o_pc);
        check_val("o_retire", 32'h0, 32'(o_retire));
        check_val("o_rd_wr_en", 32'h0, 32'(o_rd_wr_en));
        check_val("o_end_flag", 32'h0, 32'(o_end_flag));
        repeat (6) begin
            @(negedge i_clk);
            check_val("o_retire", 32'h0, 32'(o_retire));
            check_val("o_pc", model_pc, o_pc);
        end
    endtask

    task automatic test_op_imm();
        logic [31:0] rnd;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic        alt;
        rnd = $random(seed);
        load_reg(5'd1, rnd);
        rnd = $random(seed);
        load_reg(5'd2, rnd | 32'h8000_0000);
        for (int k = 0; k < 9; k++) begin
            rnd = $random(seed);
            f3  = IMM_F3[k];
            alt = (k == 8);
            rs1 = (k % 2 == 1) ? 5'd2 : 5'd1;
            imm = rnd[11:0];
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm = {1'b0, alt, 5'b00000, rnd[4:0]};
            end
            exec_check(enc_i(imm, rs1, f3, 5'(3 + k), OPC_OP_IMM), 1'b1,
                       alu_ref(f3, alt, model_x[rs1], {{20{imm[11]}}, imm}),
                       model_pc + 32'd4, 1'b0);
        end
        // Write to x0 is reported, then x0 must still read zero
        exec_check(enc_i(12'h123, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 1'b1,
                   model_x[1] + 32'h123, model_pc + 32'd4, 1'b0);
        exec_check(enc_i(12'h005, 5'd0, 3'b000, 5'd12, OPC_OP_IMM), 1'b1, 32'd5,
                   model_pc + 32'd4, 1'b0);
    endtask

    task automatic test_op_reg();
        logic [31:0] rnd;
        logic [4:0]  rs1;
        rnd = $random(seed);
        load_reg(5'd13, rnd);
        rnd = $random(seed);
        load_reg(5'd14, rnd);
        rnd = $random(seed);
        load_reg(5'd15, rnd | 32'h8000_0000);
        for (int k = 0; k < 10; k++) begin
            rs1 = (k % 2 == 1) ? 5'd15 : 5'd13;
            exec_check(enc_r(REG_ALT[k] ? 7'h20 : 7'h00, 5'd14, rs1, REG_F3[k], 5'(16 + k)),
                       1'b1, alu_ref(REG_F3[k], REG_ALT[k], model_x[rs1], model_x[14]),
                       model_pc + 32'd4, 1'b0);
        end
    endtask

    task automatic test_upper();
        logic [31:0] rnd;
        rnd = $random(seed);
        exec_check(enc_u(rnd[19:0], 5'd26, OPC_LUI), 1'b1, {rnd[19:0], 12'h000},
                   model_pc + 32'd4, 1'b0);
        rnd = $random(seed);
        exec_check(enc_u(rnd[31:12], 5'd27, OPC_AUIPC), 1'b1, model_pc + {rnd[31:12], 12'h000},
                   model_pc + 32'd4, 1'b0);
    endtask

    task automatic test_branches();
        logic [4:0] ra;
        logic [4:0] rb;
        logic       taken;
        load_reg(5'd28, 32'd5);
        load_reg(5'd29, 32'hffff_fffd);
        // Operand pairs (x28,x28) (x28,x29) (x29,x28) give both outcomes for every branch
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                ra    = (p == 2) ? 5'd29 : 5'd28;
                rb    = (p == 1) ? 5'd29 : 5'd28;
                taken = br_ref(BR_F3[k], model_x[ra], model_x[rb]);
                exec_check(enc_b(13'd16, rb, ra, BR_F3[k]), 1'b0, 32'h0,
                           taken ? model_pc + 32'd16 : model_pc + 32'd4, 1'b0);
            end
        end
    endtask

    task automatic test_jumps();
        exec_check(enc_j(21'd16, 5'd30), 1'b1, model_pc + 32'd4, model_pc + 32'd16, 1'b0);
        exec_check(enc_i(12'h021, 5'd30, 3'b000, 5'd31, OPC_JALR), 1'b1, model_pc + 32'd4,
                   (model_x[30] + 32'h21) & ~32'h1, 1'b0);
        exec_check(32'h0010_0073, 1'b0, 32'h0, model_pc + 32'd4, 1'b1);
        exec_check(enc_i(12'h004, 5'd1, 3'b010, 5'd5, OPC_LOAD), 1'b0, 32'h0,
                   model_pc + 32'd4, 1'b0);
    endtask

    initial begin
        i_arst_n     <= 1'b0;
        i_inst_valid <= 1'b0;
        i_inst       <= '0;
        model_pc = 32'h0;
        for (int r = 0; r < 32; r++) begin
            model_x[r] = 32'h0;
        end
        repeat (16) @(posedge i_clk);
        i_arst_n <= 1'b1;
        @(negedge i_clk);
        test_reset();
        test_op_imm();
        test_op_reg();
        test_upper();
        test_branches();
        test_jumps();
        $display("Errors: %0d after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verilog/rv_core.sv */
module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_inst_valid,
    input  logic [rv_pkg::INST_W-1:0]   i_inst,
    output logic [rv_pkg::XLEN-1:0]     o_pc,
    output logic                        o_retire,
    output logic                        o_rd_wr_en,
    output logic [rv_pkg::GPR_ID_W-1:0] o_rd_id,
    output logic [rv_pkg::XLEN-1:0]     o_rd_data,
    output logic                        o_end_flag
);

    logic [rv_pkg::GPR_ID_W-1:0] w_rs1_id;
    logic [rv_pkg::GPR_ID_W-1:0] w_rs2_id;
    logic [rv_pkg::XLEN-1:0]     w_rs1_data;
    logic [rv_pkg::XLEN-1:0]     w_rs2_data;
    logic [rv_pkg::XLEN-1:0]     w_alu_res;
    logic                        w_br_taken;
    logic                        w_gpr_wr_en;
    logic [rv_pkg::GPR_ID_W-1:0] w_gpr_wr_id;
    logic [rv_pkg::XLEN-1:0]     w_gpr_wr_data;

    dec_if u_dec_if ();

    idu u_idu (
        .i_inst       (i_inst),
        .i_inst_valid (i_inst_valid),
        .i_pc         (o_pc),
        .i_rs1_data   (w_rs1_data),
        .i_rs2_data   (w_rs2_data),
        .o_rs1_id     (w_rs1_id),
        .o_rs2_id     (w_rs2_id),
        .o_dec        (u_dec_if)
    );

    gpr_file u_gpr_file (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rs1_id   (w_rs1_id),
        .i_rs2_id   (w_rs2_id),
        .o_rs1_data (w_rs1_data),
        .o_rs2_data (w_rs2_data),
        .i_wr_en    (w_gpr_wr_en),
        .i_wr_id    (w_gpr_wr_id),
        .i_wr_data  (w_gpr_wr_data)
    );

    exu_alu u_exu_alu (
        .o_exe      (u_dec_if),
        .o_alu_res  (w_alu_res),
        .o_br_taken (w_br_taken)
    );

    wbu #(
        .RESET_PC (RESET_PC)
    ) u_wbu (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_res         (u_dec_if),
        .i_alu_res     (w_alu_res),
        .i_br_taken    (w_br_taken),
        .o_pc          (o_pc),
        .o_gpr_wr_en   (w_gpr_wr_en),
        .o_gpr_wr_id   (w_gpr_wr_id),
        .o_gpr_wr_data (w_gpr_wr_data),
        .o_retire      (o_retire),
        .o_rd_wr_en    (o_rd_wr_en),
        .o_rd_id       (o_rd_id),
        .o_rd_data     (o_rd_data),
        .o_end_flag    (o_end_flag)
    );

endmodule

/* verilog/wbu.sv */
module wbu #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    dec_if.res                          i_res,
    input  logic [rv_pkg::XLEN-1:0]     i_alu_res,
    input  logic                        i_br_taken,
    output logic [rv_pkg::XLEN-1:0]     o_pc,
    output logic                        o_gpr_wr_en,
    output logic [rv_pkg::GPR_ID_W-1:0] o_gpr_wr_id,
    output logic [rv_pkg::XLEN-1:0]     o_gpr_wr_data,
    output logic                        o_retire,
    output logic                        o_rd_wr_en,
    output logic [rv_pkg::GPR_ID_W-1:0] o_rd_id,
    output logic [rv_pkg::XLEN-1:0]     o_rd_data,
    output logic                        o_end_flag
);

    logic [rv_pkg::XLEN-1:0]     r_pc;
    logic [rv_pkg::XLEN-1:0]     w_seq_pc;
    logic [rv_pkg::XLEN-1:0]     w_next_pc;
    logic [rv_pkg::XLEN-1:0]     w_wb_data;
    logic                        r_retire;
    logic                        r_rd_wr_en;
    logic                        r_end_flag;
    logic [rv_pkg::GPR_ID_W-1:0] r_rd_id;
    logic [rv_pkg::XLEN-1:0]     r_rd_data;

    assign w_seq_pc = i_res.pc + rv_pkg::NOP_PC_STEP;

    always_comb begin
        if ((i_res.jmp == rv_pkg::JMP_BRANCH) && i_br_taken) begin
            w_next_pc = i_res.pc + i_res.imm;
        end else if (i_res.jmp == rv_pkg::JMP_JUMP) begin
            w_next_pc = i_alu_res;
        end else begin
            w_next_pc = w_seq_pc;
        end
    end

    // Link address for jumps
    assign w_wb_data = (i_res.jmp == rv_pkg::JMP_JUMP) ? w_seq_pc : i_alu_res;

    assign o_gpr_wr_en   = i_res.rd_wr_en;
    assign o_gpr_wr_id   = i_res.rd_id;
    assign o_gpr_wr_data = w_wb_data;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_pc <= RESET_PC;
        end else if (i_res.inst_ok) begin
            r_pc <= w_next_pc;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_retire   <= 1'b0;
            r_rd_wr_en <= 1'b0;
            r_end_flag <= 1'b0;
        end else begin
            r_retire   <= i_res.inst_ok;
            r_rd_wr_en <= i_res.rd_wr_en;
            r_end_flag <= i_res.end_flag;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_res.inst_ok) begin
            r_rd_id   <= i_res.rd_id;
            r_rd_data <= w_wb_data;
        end
    end

    assign o_pc       = r_pc;
    assign o_retire   = r_retire;
    assign o_rd_wr_en = r_rd_wr_en;
    assign o_rd_id    = r_rd_id;
    assign o_rd_data  = r_rd_data;
    assign o_end_flag = r_end_flag;

    // No misaligned jump or branch target may be taken
    a_pc_aligned: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        i_res.inst_ok |-> (w_next_pc[1:0] == 2'b00)
    ) else $error("wbu: misaligned next PC %h", w_next_pc);

endmodule

/* verilog/exu_alu.sv */
module exu_alu (
    dec_if.exe                      o_exe,
    output logic [rv_pkg::XLEN-1:0] o_alu_res,
    output logic                    o_br_taken
);

    logic [rv_pkg::XLEN-1:0] w_a;
    logic [rv_pkg::XLEN-1:0] w_b;
    logic [rv_pkg::XLEN-1:0] w_sum;
    logic [4:0]              w_shamt;
    logic                    w_eq;
    logic                    w_lt;
    logic                    w_ltu;

    assign w_a     = o_exe.opnd1;
    assign w_b     = o_exe.opnd2;
    assign w_sum   = w_a + w_b;
    assign w_shamt = w_b[4:0];

    // Comparisons shared by SLT and branches
    assign w_eq  = (w_a == w_b);
    assign w_lt  = ($signed(w_a) < $signed(w_b));
    assign w_ltu = (w_a < w_b);

    always_comb begin
        o_alu_res  = '0;
        o_br_taken = 1'b0;
        case (o_exe.alu_op)
            rv_pkg::ALU_ADD:  o_alu_res = w_sum;
            rv_pkg::ALU_SUB:  o_alu_res = w_a - w_b;
            rv_pkg::ALU_SLL:  o_alu_res = w_a << w_shamt;
            rv_pkg::ALU_SLT:  o_alu_res = {{(rv_pkg::XLEN-1){1'b0}}, w_lt};
            rv_pkg::ALU_SLTU: o_alu_res = {{(rv_pkg::XLEN-1){1'b0}}, w_ltu};
            rv_pkg::ALU_XOR:  o_alu_res = w_a ^ w_b;
            rv_pkg::ALU_SRL:  o_alu_res = w_a >> w_shamt;
            rv_pkg::ALU_SRA:  o_alu_res = $unsigned($signed(w_a) >>> w_shamt);
            rv_pkg::ALU_OR:   o_alu_res = w_a | w_b;
            rv_pkg::ALU_AND:  o_alu_res = w_a & w_b;
            rv_pkg::ALU_JALR: o_alu_res = {w_sum[rv_pkg::XLEN-1:1], 1'b0};
            rv_pkg::ALU_BEQ:  o_br_taken = w_eq;
            rv_pkg::ALU_BNE:  o_br_taken = !w_eq;
            rv_pkg::ALU_BLT:  o_br_taken = w_lt;
            rv_pkg::ALU_BGE:  o_br_taken = !w_lt;
            rv_pkg::ALU_BLTU: o_br_taken = w_ltu;
            rv_pkg::ALU_BGEU: o_br_taken = !w_ltu;
            default: begin
                o_alu_res  = '0;
                o_br_taken = 1'b0;
            end
        endcase
    end

endmodule

/* verilog/gpr_file.sv */
module gpr_file (
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic [rv_pkg::GPR_ID_W-1:0] i_rs1_id,
    input  logic [rv_pkg::GPR_ID_W-1:0] i_rs2_id,
    output logic [rv_pkg::XLEN-1:0]     o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]     o_rs2_data,
    input  logic                        i_wr_en,
    input  logic [rv_pkg::GPR_ID_W-1:0] i_wr_id,
    input  logic [rv_pkg::XLEN-1:0]     i_wr_data
);

    localparam int DEPTH = 1 << rv_pkg::GPR_ID_W;

    logic [rv_pkg::XLEN-1:0] r_gpr [DEPTH];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                r_gpr[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_id != '0)) begin
            r_gpr[i_wr_id] <= i_wr_data;
        end
    end

    assign o_rs1_data = r_gpr[i_rs1_id];
    assign o_rs2_data = r_gpr[i_rs2_id];

    // x0 survives every write-back from wbu
    a_x0_zero: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        (i_rs1_id == '0) |-> (o_rs1_data == '0)
    ) else $error("gpr_file: x0 read nonzero");

endmodule

/* verilog/idu.sv */
module idu (
    input  logic [rv_pkg::INST_W-1:0]   i_inst,
    input  logic                        i_inst_valid,
    input  logic [rv_pkg::XLEN-1:0]     i_pc,
    input  logic [rv_pkg::XLEN-1:0]     i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]     i_rs2_data,
    output logic [rv_pkg::GPR_ID_W-1:0] o_rs1_id,
    output logic [rv_pkg::GPR_ID_W-1:0] o_rs2_id,
    dec_if.dec                          o_dec
);

    rv_pkg::opcode_e                 w_opcode;
    logic [rv_pkg::FUNCT3_W-1:0]     w_funct3;
    logic                            w_alt;
    logic [rv_pkg::XLEN-1:0]         w_imm_i;
    logic [rv_pkg::XLEN-1:0]         w_imm_b;
    logic [rv_pkg::XLEN-1:0]         w_imm_u;
    logic [rv_pkg::XLEN-1:0]         w_imm_j;
    logic [rv_pkg::XLEN-1:0]         w_imm;
    rv_pkg::alu_op_e                 w_alu_op;
    rv_pkg::src1_e                   w_src1;
    rv_pkg::src2_e                   w_src2;
    rv_pkg::jmp_e                    w_jmp;
    logic                            w_wr_en;
    logic                            w_ebreak;

    // Shared by OP and OP_IMM
    // SUB only exists in register form
    function automatic rv_pkg::alu_op_e arith_op(
        input logic [2:0] f3,
        input logic       alt,
        input logic       sub_ok
    );
        case (f3)
            3'b000:  return (sub_ok && alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    assign w_opcode = rv_pkg::opcode_e'(i_inst[rv_pkg::OPCODE_W-1:0]);
    assign w_funct3 = i_inst[rv_pkg::FUNCT3_LSB +: rv_pkg::FUNCT3_W];
    assign w_alt    = i_inst[rv_pkg::ALT_BIT];

    assign w_imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign w_imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                      i_inst[11:8], 1'b0};
    assign w_imm_u = {i_inst[31:12], 12'h000};
    assign w_imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                      i_inst[30:21], 1'b0};

    always_comb begin
        w_alu_op = rv_pkg::ALU_X;
        w_src1   = rv_pkg::SRC1_ZERO;
        w_src2   = rv_pkg::SRC2_IMM;
        w_jmp    = rv_pkg::JMP_NONE;
        w_wr_en  = 1'b0;
        w_imm    = w_imm_i;
        case (w_opcode)
            rv_pkg::OPC_LUI: begin
                w_alu_op = rv_pkg::ALU_ADD;
                w_imm    = w_imm_u;
                w_wr_en  = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                w_alu_op = rv_pkg::ALU_ADD;
                w_src1   = rv_pkg::SRC1_PC;
                w_imm    = w_imm_u;
                w_wr_en  = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                w_alu_op = rv_pkg::ALU_ADD;
                w_src1   = rv_pkg::SRC1_PC;
                w_imm    = w_imm_j;
                w_jmp    = rv_pkg::JMP_JUMP;
                w_wr_en  = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                w_alu_op = rv_pkg::ALU_JALR;
                w_src1   = rv_pkg::SRC1_GPR;
                w_jmp    = rv_pkg::JMP_JUMP;
                w_wr_en  = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                w_src1 = rv_pkg::SRC1_GPR;
                w_src2 = rv_pkg::SRC2_GPR;
                w_imm  = w_imm_b;
                w_jmp  = rv_pkg::JMP_BRANCH;
                case (w_funct3)
                    3'b000:  w_alu_op = rv_pkg::ALU_BEQ;
                    3'b001:  w_alu_op = rv_pkg::ALU_BNE;
                    3'b100:  w_alu_op = rv_pkg::ALU_BLT;
                    3'b101:  w_alu_op = rv_pkg::ALU_BGE;
                    3'b110:  w_alu_op = rv_pkg::ALU_BLTU;
                    3'b111:  w_alu_op = rv_pkg::ALU_BGEU;
                    default: w_alu_op = rv_pkg::ALU_X;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                w_alu_op = arith_op(w_funct3, w_alt, 1'b0);
                w_src1   = rv_pkg::SRC1_GPR;
                w_wr_en  = 1'b1;
            end
            rv_pkg::OPC_OP: begin
                w_alu_op = arith_op(w_funct3, w_alt, 1'b1);
                w_src1   = rv_pkg::SRC1_GPR;
                w_src2   = rv_pkg::SRC2_GPR;
                w_wr_en  = 1'b1;
            end
            // Nothing but EBREAK matters here
            rv_pkg::OPC_SYSTEM: begin
                w_alu_op = rv_pkg::ALU_ADD;
            end
            default: begin
                w_alu_op = rv_pkg::ALU_X;
            end
        endcase
    end

    assign w_ebreak = (w_opcode == rv_pkg::OPC_SYSTEM) &&
                      (i_inst[rv_pkg::IMM12_LSB +: 12] == rv_pkg::EBREAK_IMM);

    assign o_rs1_id = i_inst[rv_pkg::RS1_LSB +: rv_pkg::GPR_ID_W];
    assign o_rs2_id = i_inst[rv_pkg::RS2_LSB +: rv_pkg::GPR_ID_W];

    always_comb begin
        case (w_src1)
            rv_pkg::SRC1_GPR: o_dec.opnd1 = i_rs1_data;
            rv_pkg::SRC1_PC:  o_dec.opnd1 = i_pc;
            default:          o_dec.opnd1 = '0;
        endcase
    end

    assign o_dec.opnd2  = (w_src2 == rv_pkg::SRC2_GPR) ? i_rs2_data : w_imm;
    assign o_dec.alu_op = w_alu_op;
    assign o_dec.imm    = w_imm;
    assign o_dec.pc     = i_pc;
    assign o_dec.rd_id  = i_inst[rv_pkg::RD_LSB +: rv_pkg::GPR_ID_W];

    // Side effects only for a valid strobe
    assign o_dec.jmp      = i_inst_valid ? w_jmp : rv_pkg::JMP_NONE;
    assign o_dec.rd_wr_en = i_inst_valid && w_wr_en;
    assign o_dec.end_flag = i_inst_valid && w_ebreak;
    assign o_dec.inst_ok  = i_inst_valid;

    // Every major opcode of the package maps to a real operation
    always_comb begin
        if (i_inst_valid && (w_opcode inside {rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC,
                rv_pkg::OPC_JAL, rv_pkg::OPC_JALR, rv_pkg::OPC_BRANCH,
                rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP, rv_pkg::OPC_SYSTEM})) begin
            a_alu_op_known: assert final (w_alu_op != rv_pkg::ALU_X)
                else $error("idu: known opcode decoded to ALU X");
        end
    end

endmodule

/* verilog/dec_if.sv */
interface dec_if;

    rv_pkg::alu_op_e               alu_op;
    logic [rv_pkg::XLEN-1:0]       opnd1;
    logic [rv_pkg::XLEN-1:0]       opnd2;
    logic [rv_pkg::XLEN-1:0]       imm;
    logic [rv_pkg::XLEN-1:0]       pc;
    rv_pkg::jmp_e                  jmp;
    logic [rv_pkg::GPR_ID_W-1:0]   rd_id;
    logic                          rd_wr_en;
    logic                          end_flag;
    // High for any accepted instruction, known or not
    logic                          inst_ok;

    modport dec (
        output alu_op, opnd1, opnd2, imm, pc, jmp,
        output rd_id, rd_wr_en, end_flag, inst_ok
    );

    modport exe (
        input alu_op, opnd1, opnd2
    );

    modport res (
        input imm, pc, jmp, rd_id, rd_wr_en, end_flag, inst_ok
    );

endinterface

/* verilog/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN     = 32;
    localparam int GPR_ID_W = 5;
    localparam int INST_W   = 32;

    // Instruction field positions
    localparam int OPCODE_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_W   = 3;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int IMM12_LSB  = 20;
    localparam int ALT_BIT    = 30;

    localparam logic [11:0]     EBREAK_IMM  = 12'h001;
    localparam logic [XLEN-1:0] NOP_PC_STEP = XLEN'(4);

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // 18 operations, so five bits
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_JALR,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_X
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_GPR,
        SRC1_PC,
        SRC1_ZERO
    } src1_e;

    typedef enum logic {
        SRC2_GPR,
        SRC2_IMM
    } src2_e;

    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_BRANCH,
        JMP_JUMP
    } jmp_e;

endpackage
